//--- project.f
+incdir+verif
src/rv_pkg.sv
src/rv_sequencer.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_core.sv
verif/tb_rv_core.sv

//--- src/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire rv_pkg::step_t    step,
  input  wire rv_pkg::alu_fun_t alu_fun,
  input  wire rv_pkg::word_t    op1,
  input  wire rv_pkg::word_t    op2,
  output rv_pkg::word_t         alu_out,
  output logic                  br_taken
);

  import rv_pkg::*;

  word_t      sum;
  word_t      result;
  logic       eq;
  logic       lt_s;
  logic       lt_u;
  logic       taken;
  logic [4:0] shamt;

  assign sum   = op1 + op2;
  assign eq    = (op1 == op2);
  assign lt_s  = ($signed(op1) < $signed(op2));
  assign lt_u  = (op1 < op2);
  assign shamt = op2[4:0];

  always_comb begin
    case (alu_fun)
      ALU_ADD:  result = sum;
      ALU_SUB:  result = op1 - op2;
      ALU_AND:  result = op1 & op2;
      ALU_OR:   result = op1 | op2;
      ALU_XOR:  result = op1 ^ op2;
      ALU_SLL:  result = op1 << shamt;
      ALU_SRL:  result = op1 >> shamt;
      ALU_SRA:  result = $signed(op1) >>> shamt;
      ALU_SLT:  result = {31'b0, lt_s};
      ALU_SLTU: result = {31'b0, lt_u};
      ALU_JALR: result = sum & ~32'd1;
      default:  result = '0;
    endcase
  end

  // Branch compare shares the operand pair
  always_comb begin
    case (alu_fun)
      BR_BEQ:  taken = eq;
      BR_BNE:  taken = !eq;
      BR_BLT:  taken = lt_s;
      BR_BGE:  taken = !lt_s;
      BR_BLTU: taken = lt_u;
      BR_BGEU: taken = !lt_u;
      default: taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alu_out  <= '0;
      br_taken <= 1'b0;
    end else if (step == STEP_EX) begin
      alu_out  <= result;
      br_taken <= taken;
    end
  end

endmodule

`default_nettype wire

//--- src/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                stall,
  input  wire rv_pkg::word_t inst,
  input  wire rv_pkg::word_t rdata,
  output rv_pkg::word_t      addr_i,
  output rv_pkg::word_t      addr_d,
  output rv_pkg::word_t      wdata,
  output logic               wen,
  output logic               exit
);

  import rv_pkg::*;

  step_t     step;
  word_t     pc;
  word_t     pc_plus4;
  alu_fun_t  alu_fun;
  wb_sel_t   wb_sel;
  logic      rf_wen;
  logic      mem_wen;
  logic      jump;
  word_t     op1;
  word_t     op2;
  word_t     br_target;
  reg_addr_t rd;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     alu_out;
  logic      br_taken;
  word_t     wb_data;

  rv_sequencer i_rv_sequencer (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .br_taken  (br_taken),
    .jump      (jump),
    .br_target (br_target),
    .alu_out   (alu_out),
    .step      (step),
    .pc        (pc)
  );

  rv_decoder i_rv_decoder (
    .clk       (clk),
    .rst_n     (rst_n),
    .step      (step),
    .inst      (inst),
    .pc        (pc),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rd        (rd),
    .alu_fun   (alu_fun),
    .wb_sel    (wb_sel),
    .rf_wen    (rf_wen),
    .mem_wen   (mem_wen),
    .jump      (jump),
    .op1       (op1),
    .op2       (op2),
    .br_target (br_target)
  );

  rv_regfile i_rv_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .step     (step),
    .wen      (rf_wen),
    .rd       (rd),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .wb_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_alu i_rv_alu (
    .clk      (clk),
    .rst_n    (rst_n),
    .step     (step),
    .alu_fun  (alu_fun),
    .op1      (op1),
    .op2      (op2),
    .alu_out  (alu_out),
    .br_taken (br_taken)
  );

  //****************************************
  // Memory ports
  assign addr_i = pc;
  assign addr_d = alu_out;
  assign wdata  = rs2_data;
  assign wen    = mem_wen && (step == STEP_MEM);

  //****************************************
  // Writeback select
  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (wb_sel)
      WB_ALU:  wb_data = alu_out;
      WB_MEM:  wb_data = rdata;
      WB_PC4:  wb_data = pc_plus4;
      default: wb_data = '0;
    endcase
  end

  assign exit = (inst == UNIMP_INST);

  a_wen_in_mem: assert property (@(posedge clk) disable iff (!rst_n)
    wen |-> step == STEP_MEM);

endmodule

`default_nettype wire

//--- src/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire rv_pkg::step_t   step,
  input  wire rv_pkg::word_t   inst,
  input  wire rv_pkg::word_t   pc,
  input  wire rv_pkg::word_t   rs1_data,
  input  wire rv_pkg::word_t   rs2_data,
  output rv_pkg::reg_addr_t    rs1_addr,
  output rv_pkg::reg_addr_t    rs2_addr,
  output rv_pkg::reg_addr_t    rd,
  output rv_pkg::alu_fun_t     alu_fun,
  output rv_pkg::wb_sel_t      wb_sel,
  output logic                 rf_wen,
  output logic                 mem_wen,
  output logic                 jump,
  output rv_pkg::word_t        op1,
  output rv_pkg::word_t        op2,
  output rv_pkg::word_t        br_target
);

  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       alt;

  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_j;
  word_t imm_u;

  op1_sel_t op1_sel;
  op2_sel_t op2_sel;

  alu_fun_t alu_fun_d;
  wb_sel_t  wb_sel_d;
  op1_sel_t op1_sel_d;
  op2_sel_t op2_sel_d;
  logic     rf_wen_d;
  logic     mem_wen_d;
  logic     jump_d;

  assign opcode   = inst[6:0];
  assign funct3   = inst[14:12];
  assign funct7   = inst[31:25];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];
  assign rd       = inst[11:7];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};

  assign br_target = pc + imm_b;

  // funct7 only matters for SUB, SRA and SRAI
  assign alt = (funct7 == F7_ALT) && (opcode == OPC_OP || funct3 == F3_SRL_SRA);

  //****************************************
  // Control decode
  always_comb begin
    alu_fun_d = ALU_NONE;
    wb_sel_d  = WB_NONE;
    op1_sel_d = OP1_RS1;
    op2_sel_d = OP2_RS2;
    rf_wen_d  = 1'b0;
    mem_wen_d = 1'b0;
    jump_d    = 1'b0;
    case (opcode)
      OPC_OP, OPC_OP_IMM: begin
        rf_wen_d  = 1'b1;
        wb_sel_d  = WB_ALU;
        op2_sel_d = (opcode == OPC_OP) ? OP2_RS2 : OP2_IMM_I;
        case (funct3)
          F3_ADD_SUB: alu_fun_d = alt ? ALU_SUB : ALU_ADD;
          F3_SLL:     alu_fun_d = ALU_SLL;
          F3_SLT:     alu_fun_d = ALU_SLT;
          F3_SLTU:    alu_fun_d = ALU_SLTU;
          F3_XOR:     alu_fun_d = ALU_XOR;
          F3_SRL_SRA: alu_fun_d = alt ? ALU_SRA : ALU_SRL;
          F3_OR:      alu_fun_d = ALU_OR;
          default:    alu_fun_d = ALU_AND;
        endcase
      end
      OPC_LOAD: begin
        if (funct3 == F3_LW) begin
          alu_fun_d = ALU_ADD;
          op2_sel_d = OP2_IMM_I;
          wb_sel_d  = WB_MEM;
          rf_wen_d  = 1'b1;
        end
      end
      OPC_STORE: begin
        if (funct3 == F3_SW) begin
          alu_fun_d = ALU_ADD;
          op2_sel_d = OP2_IMM_S;
          mem_wen_d = 1'b1;
        end
      end
      OPC_BRANCH: begin
        case (funct3)
          F3_BEQ:  alu_fun_d = BR_BEQ;
          F3_BNE:  alu_fun_d = BR_BNE;
          F3_BLT:  alu_fun_d = BR_BLT;
          F3_BGE:  alu_fun_d = BR_BGE;
          F3_BLTU: alu_fun_d = BR_BLTU;
          F3_BGEU: alu_fun_d = BR_BGEU;
          default: alu_fun_d = ALU_NONE;
        endcase
      end
      OPC_JAL: begin
        alu_fun_d = ALU_ADD;
        op1_sel_d = OP1_PC;
        op2_sel_d = OP2_IMM_J;
        wb_sel_d  = WB_PC4;
        rf_wen_d  = 1'b1;
        jump_d    = 1'b1;
      end
      OPC_JALR: begin
        if (funct3 == F3_JALR) begin
          alu_fun_d = ALU_JALR;
          op2_sel_d = OP2_IMM_I;
          wb_sel_d  = WB_PC4;
          rf_wen_d  = 1'b1;
          jump_d    = 1'b1;
        end
      end
      OPC_LUI, OPC_AUIPC: begin
        alu_fun_d = ALU_ADD;
        op1_sel_d = (opcode == OPC_LUI) ? OP1_ZERO : OP1_PC;
        op2_sel_d = OP2_IMM_U;
        wb_sel_d  = WB_ALU;
        rf_wen_d  = 1'b1;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alu_fun <= ALU_NONE;
      wb_sel  <= WB_NONE;
      op1_sel <= OP1_RS1;
      op2_sel <= OP2_RS2;
      rf_wen  <= 1'b0;
      mem_wen <= 1'b0;
      jump    <= 1'b0;
    end else if (step == STEP_ID) begin
      alu_fun <= alu_fun_d;
      wb_sel  <= wb_sel_d;
      op1_sel <= op1_sel_d;
      op2_sel <= op2_sel_d;
      rf_wen  <= rf_wen_d;
      mem_wen <= mem_wen_d;
      jump    <= jump_d;
    end
  end

  //****************************************
  // Operand select
  always_comb begin
    case (op1_sel)
      OP1_RS1: op1 = rs1_data;
      OP1_PC:  op1 = pc;
      default: op1 = '0;
    endcase
  end

  always_comb begin
    case (op2_sel)
      OP2_RS2:   op2 = rs2_data;
      OP2_IMM_I: op2 = imm_i;
      OP2_IMM_S: op2 = imm_s;
      OP2_IMM_J: op2 = imm_j;
      OP2_IMM_U: op2 = imm_u;
      default:   op2 = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/rv_pkg.sv
`default_nettype none

package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  typedef enum logic [2:0] {
    STEP_IDLE,
    STEP_IF,
    STEP_ID,
    STEP_EX,
    STEP_MEM,
    STEP_WB
  } step_t;

  // NONE first so a cleared register decodes to no operation
  typedef enum logic [4:0] {
    ALU_NONE,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_JALR,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_BLTU,
    BR_BGEU
  } alu_fun_t;

  typedef enum logic [1:0] {
    OP1_RS1,
    OP1_PC,
    OP1_ZERO
  } op1_sel_t;

  typedef enum logic [2:0] {
    OP2_RS2,
    OP2_IMM_I,
    OP2_IMM_S,
    OP2_IMM_J,
    OP2_IMM_U
  } op2_sel_t;

  typedef enum logic [1:0] {
    WB_NONE,
    WB_ALU,
    WB_MEM,
    WB_PC4
  } wb_sel_t;

  localparam word_t START_ADDR = 32'h0000_0000;
  localparam word_t UNIMP_INST = 32'hc000_1073;

  //****************************************
  // Opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  //****************************************
  // Funct fields
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [2:0] F3_BLT     = 3'b100;
  localparam logic [2:0] F3_BGE     = 3'b101;
  localparam logic [2:0] F3_BLTU    = 3'b110;
  localparam logic [2:0] F3_BGEU    = 3'b111;
  localparam logic [2:0] F3_LW      = 3'b010;
  localparam logic [2:0] F3_SW      = 3'b010;
  localparam logic [2:0] F3_JALR    = 3'b000;

  // SUB and SRA select
  localparam logic [6:0] F7_ALT = 7'b0100000;

endpackage

`default_nettype wire

//--- src/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire rv_pkg::step_t     step,
  input  wire                    wen,
  input  wire rv_pkg::reg_addr_t rd,
  input  wire rv_pkg::reg_addr_t rs1_addr,
  input  wire rv_pkg::reg_addr_t rs2_addr,
  input  wire rv_pkg::word_t     wb_data,
  output rv_pkg::word_t          rs1_data,
  output rv_pkg::word_t          rs2_data
);

  import rv_pkg::*;

  word_t regs [32];

  // x0 is hardwired to zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (step == STEP_WB && wen && rd != '0) begin
      regs[rd] <= wb_data;
    end
  end

endmodule

`default_nettype wire

//--- src/rv_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module rv_sequencer (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                stall,
  input  wire                br_taken,
  input  wire                jump,
  input  wire rv_pkg::word_t br_target,
  input  wire rv_pkg::word_t alu_out,
  output rv_pkg::step_t      step,
  output rv_pkg::word_t      pc
);

  import rv_pkg::*;

  word_t pc_plus4;
  word_t pc_next;

  assign pc_plus4 = pc + 32'd4;

  // Branch wins over jump, jump over increment
  always_comb begin
    if (br_taken) begin
      pc_next = br_target;
    end else if (jump) begin
      pc_next = alu_out;
    end else begin
      pc_next = pc_plus4;
    end
  end

  //****************************************
  // Step machine
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step <= STEP_IDLE;
    end else if (!stall) begin
      case (step)
        STEP_IDLE: step <= STEP_IF;
        STEP_IF:   step <= STEP_ID;
        STEP_ID:   step <= STEP_EX;
        STEP_EX:   step <= STEP_MEM;
        STEP_MEM:  step <= STEP_WB;
        STEP_WB:   step <= STEP_IF;
        default:   step <= STEP_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= START_ADDR;
    end else if (!stall && step == STEP_WB) begin
      pc <= pc_next;
    end
  end

  a_step_legal: assert property (@(posedge clk) disable iff (!rst_n)
    step inside {STEP_IDLE, STEP_IF, STEP_ID, STEP_EX, STEP_MEM, STEP_WB});

  // Targets from decoder and ALU keep the PC on word boundaries
  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    (step == STEP_WB && !stall) |=> pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- verif/rv_core_tests.svh
`ifndef RV_CORE_TESTS_SVH
`define RV_CORE_TESTS_SVH

//****************************************
// Register and immediate ALU operations
task automatic alu_ops();
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] r;
  logic [11:0] imm;
  logic        alt;
  for (int round = 0; round < 2; round++) begin
    begin_test();
    a = lcg_next();
    b = lcg_next();
    load_reg(5'd1, a);
    load_reg(5'd2, b);
    for (int f3 = 0; f3 < 8; f3++) begin
      for (int k = 0; k < 2; k++) begin
        alt = k[0];
        if (alt && f3 != 0 && f3 != 5) begin
          continue;
        end
        emit(r_type(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3[2:0], 5'd3));
        record(5'd3, ref_alu(f3[2:0], alt, a, b));
        // No immediate form of SUB
        if (alt && f3 == 0) begin
          continue;
        end
        r = lcg_next();
        imm = (f3 == 1 || f3 == 5) ? {alt ? 7'h20 : 7'h00, r[4:0]} : r[11:0];
        emit(i_type(imm, 5'd1, f3[2:0], 5'd4, OP_IMM));
        record(5'd4, ref_alu(f3[2:0], alt, a, {{20{imm[11]}}, imm}));
      end
    end
    execute($sformatf("alu round %0d", round), 0, 0);
  end
endtask

task automatic load_store_copy();
  logic [31:0] v;
  logic [31:0] w;
  begin_test();
  v = lcg_next();
  w = lcg_next();
  dmem[32] = v;
  dmem[33] = w;
  emit(i_type(12'h080, 5'd0, 3'b010, 5'd3, OP_LOAD));
  record(5'd3, v);
  load_reg(5'd4, 32'h40);
  emit(i_type(12'h040, 5'd4, 3'b010, 5'd5, OP_LOAD));
  record(5'd5, v);
  // Negative offset reaches 0x84
  load_reg(5'd7, 32'h88);
  emit(i_type(12'hffc, 5'd7, 3'b010, 5'd6, OP_LOAD));
  record(5'd6, w);
  emit(i_type(12'h123, 5'd0, 3'b000, 5'd0, OP_IMM));
  record(5'd0, 32'h0);
  emit(i_type(12'h080, 5'd0, 3'b010, 5'd0, OP_LOAD));
  record(5'd0, 32'h0);
  execute("load store", 0, 0);
endtask

//****************************************
// Branches
task automatic branch_case(input logic [2:0] f3, input logic [31:0] x,
                           input logic [31:0] y, input logic taken);
  logic [31:0] slot_n;
  logic [31:0] slot_t;
  load_reg(5'd1, x);
  load_reg(5'd2, y);
  slot_n = next_slot();
  slot_t = next_slot();
  emit(b_type(13'd16, 5'd2, 5'd1, f3));
  emit(i_type(12'h011, 5'd0, 3'b000, 5'd3, OP_IMM));
  emit(s_type(slot_n[11:0], 5'd3, 5'd0));
  emit(j_type(21'd12, 5'd0));
  emit(i_type(12'h022, 5'd0, 3'b000, 5'd3, OP_IMM));
  emit(s_type(slot_t[11:0], 5'd3, 5'd0));
  expect_word(slot_n, taken ? fill_data(slot_n[9:2]) : 32'h11);
  expect_word(slot_t, taken ? 32'h22 : fill_data(slot_t[9:2]));
endtask

task automatic branch_pairs();
  logic [2:0]  f3s [6];
  string       names [6];
  logic [31:0] xs [3];
  logic [31:0] ys [3];
  logic [31:0] a;
  logic [31:0] b;
  int          t_idx;
  int          n_idx;
  f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
  names = '{"beq", "bne", "blt", "bge", "bltu", "bgeu"};
  for (int i = 0; i < 6; i++) begin
    begin_test();
    a = lcg_next();
    b = lcg_next();
    if (a == b) begin
      b = ~a;
    end
    // With a != b one ordering is taken and another is not
    xs = '{a, a, b};
    ys = '{a, b, a};
    t_idx = 0;
    n_idx = 0;
    for (int c = 2; c >= 0; c--) begin
      if (br_ref(f3s[i], xs[c], ys[c])) begin
        t_idx = c;
      end else begin
        n_idx = c;
      end
    end
    branch_case(f3s[i], xs[t_idx], ys[t_idx], 1'b1);
    branch_case(f3s[i], xs[n_idx], ys[n_idx], 1'b0);
    execute(names[i], 0, 0);
  end
endtask

task automatic jumps_and_upper();
  logic [31:0] jalr_pc;
  logic [31:0] target;
  logic [31:0] q;
  logic [31:0] r;
  begin_test();
  emit(j_type(21'd8, 5'd1));
  emit(i_type(12'h033, 5'd0, 3'b000, 5'd3, OP_IMM));
  record(5'd1, 32'd4);
  record(5'd3, 32'd0);
  jalr_pc = (prog.size() + 1) * 4;
  target = jalr_pc + 8;
  // Odd base so bit 0 of the sum must be dropped
  emit(i_type(target[11:0] - 12'd3, 5'd0, 3'b000, 5'd5, OP_IMM));
  emit(i_type(12'd4, 5'd5, 3'b000, 5'd6, OP_JALR));
  emit(i_type(12'h044, 5'd0, 3'b000, 5'd3, OP_IMM));
  record(5'd6, jalr_pc + 4);
  record(5'd3, 32'd0);
  r = lcg_next();
  emit(u_type(r[31:12], 5'd7, OP_LUI));
  record(5'd7, {r[31:12], 12'h000});
  q = prog.size() * 4;
  r = lcg_next();
  emit(u_type(r[31:12], 5'd8, OP_AUIPC));
  record(5'd8, {r[31:12], 12'h000} + q);
  execute("jumps", 0, 0);
endtask

//****************************************
// Stall, exit and step timing
task automatic stall_hold();
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] snap [256];
  int          stall_at;
  int          stall_len;
  begin_test();
  a = lcg_next();
  b = lcg_next();
  load_reg(5'd1, a);
  load_reg(5'd2, b);
  emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
  record(5'd3, a + b);
  emit(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));
  record(5'd3, a - b);
  emit(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd3));
  record(5'd3, a ^ b);
  emit(i_type(SLOT_BASE[11:0], 5'd0, 3'b010, 5'd6, OP_LOAD));
  record(5'd6, a + b);
  execute("stall reference", 0, 0);
  snap = dmem;
  stall_at = 8 + lcg_next() % 40;
  // At least one full instruction length so a moving PC would show
  stall_len = 5 + lcg_next() % 11;
  hold_reset();
  execute("stall", stall_at, stall_len);
  for (int i = 0; i < 256; i++) begin
    check_eq($sformatf("stall dmem[%0d]", i), snap[i], dmem[i]);
  end
endtask

task automatic exit_timing();
  int          cycles;
  int          last_change;
  int          changes;
  int          wen_cycles;
  logic [31:0] prev_addr;
  logic [31:0] unimp_addr;
  begin_test();
  emit(i_type(12'd5, 5'd0, 3'b000, 5'd1, OP_IMM));
  emit(i_type(12'd3, 5'd1, 3'b000, 5'd2, OP_IMM));
  record(5'd2, 32'd8);
  emit(i_type(12'hfff, 5'd2, 3'b000, 5'd3, OP_IMM));
  unimp_addr = prog.size() * 4;
  load_imem();
  @(negedge clk);
  check_eq("reset addr_i", 32'h0, addr_i);
  check_eq("reset wen", 32'h0, wen);
  check_eq("reset exit", 32'h0, exit);
  @(negedge clk);
  rst_n = 1'b1;
  cycles = 0;
  last_change = 0;
  changes = 0;
  wen_cycles = 0;
  prev_addr = addr_i;
  while (exit !== 1'b1 && cycles < RUN_BUDGET * 5) begin
    @(negedge clk);
    cycles++;
    if (wen) begin
      wen_cycles++;
    end
    // First instruction also spends one cycle in IDLE
    if (addr_i !== prev_addr) begin
      check_eq("addr_i interval", (changes == 0) ? 6 : 5, cycles - last_change);
      changes++;
      last_change = cycles;
      prev_addr = addr_i;
    end
    check_eq("exit level", addr_i == unimp_addr, exit);
  end
  check_eq("exit seen", 32'h1, exit);
  check_eq("addr_i steps", unimp_addr / 4, changes);
  check_eq("store cycles", 32'h1, wen_cycles);
  compare_expected("exit timing");
endtask

`endif

//--- verif/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

  // Instructions allowed per program run, and number of runs
  localparam int RUN_BUDGET  = 64;
  localparam int NUM_RUNS    = 13;
  localparam int WATCHDOG_NS = NUM_RUNS * RUN_BUDGET * 5 * 8 * 2;

  localparam logic [31:0] UNIMP     = 32'hc000_1073;
  localparam logic [31:0] SLOT_BASE = 32'h0000_0200;

  localparam logic [6:0] OP_REG   = 7'b0110011;
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_LOAD  = 7'b0000011;
  localparam logic [6:0] OP_JALR  = 7'b1100111;
  localparam logic [6:0] OP_LUI   = 7'b0110111;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;

  logic        clk;
  logic        rst_n;
  logic        stall;
  logic [31:0] inst;
  logic [31:0] rdata;
  logic [31:0] addr_i;
  logic [31:0] addr_d;
  logic [31:0] wdata;
  logic        wen;
  logic        exit;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];

  // Program under construction and the stores it should leave behind
  logic [31:0] prog [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_val [$];

  logic [31:0] rng_state = 32'hd43f_67a5;
  int          slot_count = 0;
  int          checks = 0;
  int          errors = 0;

  rv_core i_rv_core (
    .clk    (clk),
    .rst_n  (rst_n),
    .stall  (stall),
    .inst   (inst),
    .rdata  (rdata),
    .addr_i (addr_i),
    .addr_d (addr_d),
    .wdata  (wdata),
    .wen    (wen),
    .exit   (exit)
  );

  //****************************************
  // Memory models
  assign inst  = imem[addr_i[9:2]];
  assign rdata = dmem[addr_d[9:2]];

  always @(posedge clk) begin
    if (wen) begin
      dmem[addr_d[9:2]] <= wdata;
    end
  end

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //****************************************
  // Helpers
  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic [31:0] fill_data(input logic [7:0] idx);
    return {16'hda7a, 6'b0, idx, 2'b00};
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // RV32I integer results for OP and OP-IMM
  function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic br_ref(input logic [2:0] f3, input logic [31:0] a,
                                  input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return !($signed(a) < $signed(b));
      3'd6: return a < b;
      default: return !(a < b);
    endcase
  endfunction

  function automatic logic [31:0] next_slot();
    logic [31:0] addr;
    addr = SLOT_BASE + slot_count * 4;
    slot_count++;
    return addr;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic fill_memories();
    for (int i = 0; i < 256; i++) begin
      imem[i] = {16'h1f1f, 6'b0, i[7:0], 2'b00};
      dmem[i] = fill_data(i[7:0]);
    end
  endtask

  task automatic hold_reset();
    @(negedge clk);
    rst_n = 1'b0;
    stall = 1'b0;
    fill_memories();
  endtask

  task automatic begin_test();
    hold_reset();
    prog.delete();
    exp_addr.delete();
    exp_val.delete();
    slot_count = 0;
  endtask

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  task automatic expect_word(input logic [31:0] addr, input logic [31:0] value);
    exp_addr.push_back(addr);
    exp_val.push_back(value);
  endtask

  // LUI plus ADDI, upper part rounded for the signed low half
  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] hi;
    hi = value + 32'h800;
    emit(u_type(hi[31:12], rd, OP_LUI));
    emit(i_type(value[11:0], rd, 3'b000, rd, OP_IMM));
  endtask

  task automatic record(input logic [4:0] rs, input logic [31:0] value);
    logic [31:0] addr;
    addr = next_slot();
    emit(s_type(addr[11:0], rs, 5'd0));
    expect_word(addr, value);
  endtask

  task automatic load_imem();
    for (int i = 0; i < prog.size(); i++) begin
      imem[i] = prog[i];
    end
    imem[prog.size()] = UNIMP;
  endtask

  task automatic compare_expected(input string name);
    for (int k = 0; k < exp_addr.size(); k++) begin
      check_eq($sformatf("%s word %h", name, exp_addr[k]), exp_val[k],
               dmem[exp_addr[k][9:2]]);
    end
  endtask

  // Releases reset, optionally holds stall, waits for exit
  task automatic execute(input string name, input int stall_at, input int stall_len);
    int          cycles;
    int          limit;
    logic [31:0] held_addr;
    logic        held_wen;
    limit = RUN_BUDGET * 5 + stall_len;
    load_imem();
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    cycles = 0;
    while (exit !== 1'b1 && cycles < limit) begin
      @(negedge clk);
      cycles++;
      if (stall_len > 0 && cycles == stall_at) begin
        stall = 1'b1;
        held_addr = addr_i;
        held_wen = wen;
        repeat (stall_len) begin
          @(negedge clk);
          cycles++;
          check_eq({name, " addr_i held"}, held_addr, addr_i);
          check_eq({name, " wen held"}, held_wen, wen);
        end
        stall = 1'b0;
      end
    end
    checks++;
    assert (exit === 1'b1) else begin
      errors++;
      $display("ERROR %s: exit not raised within %0d cycles", name, limit);
    end
    compare_expected(name);
  endtask

  `include "rv_core_tests.svh"

  //****************************************
  // Sequence and watchdog
  initial begin
    rst_n = 1'b0;
    stall = 1'b0;
    fill_memories();
    alu_ops();
    load_store_copy();
    branch_pairs();
    jumps_and_upper();
    stall_hold();
    exit_timing();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS * 1ns);
    $display("ERROR: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire
